/* biu_8088.f */
hdl/biu_pkg.sv
hdl/bus_cycle_fsm.sv
hdl/bus_datapath.sv
hdl/hold_arbiter.sv
hdl/intr_ack_ctrl.sv
hdl/biu_8088.sv
sim/bus_memory_model.sv
sim/tb_biu_8088.sv

/* Makefile */
# Verilator build and run for the 8088 bus interface unit

VERILATOR ?= verilator
FILELIST  ?= biu_8088.f
TB_TOP    ?= tb_biu_8088
RTL_TOP   ?= biu_8088
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0
LINTFLAGS ?= --lint-only --assert --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_biu_8088.sv */
// testbench for the 8088 bus interface unit
// plays the core, checks bus timing, data, interrupt acknowledge and hold

`timescale 1ns/10ps

module tb_biu_8088
   import biu_pkg::*;
;

   localparam int N_RAND   = 16;
   localparam int N_ZERO   = 6;
   localparam int WORST_TX = 2 * (4 + 4) + 4 + 3 + 4;  // word, max waits, back-pressure
   localparam int LIMIT    = (16 + (2 * (N_RAND + N_ZERO) + 2) * WORST_TX + 140) * 2;

   logic clk, rst;
   logic req_valid_i, req_ready_o, rsp_valid_o, rsp_ready_i;
   logic vec_valid_o, vec_ready_i, ready_i, hold_i, intr_i;
   logic [7:0] vec_o, ad_i, ad_o, vector;
   logic [19:0] a_o;
   logic ad_oe_o, ale_o, rd_n_o, wr_n_o, den_n_o, dtr_o, iom_o, inta_n_o, hlda_o, bus_float_o;
   logic [3:0] wait_cnt;
   bus_req_t req_i;
   bus_rsp_t rsp_o;

   int cyc, pass_cnt, fail_cnt, inta_pulses;
   logic [31:0] lcg_state;
   logic cur_io, cur_write, inta_prev;
   logic [7:0] ref_mem [256];
   logic [7:0] ref_io [16];
   logic [19:0] ale_addrs [$];

   biu_8088 uut (.*);

   bus_memory_model u_mem (
      .clk(clk), .rst(rst), .a_i(a_o), .wdata_i(ad_o), .ale_i(ale_o),
      .rd_n_i(rd_n_o), .wr_n_i(wr_n_o), .inta_n_i(inta_n_o), .iom_i(iom_o),
      .wait_cnt_i(wait_cnt), .vector_i(vector), .ad_o(ad_i), .ready_o(ready_i)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // cycle count, ale address log, acknowledge pulse count, timeout
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (ale_o)
         ale_addrs.push_back(a_o);
      inta_prev <= inta_n_o;
      if (inta_n_o && !inta_prev)
         inta_pulses <= inta_pulses + 1;
      if (cyc > LIMIT) begin
         $display("timeout after %0d cycles, DUT stopped answering", cyc);
         $display("Test FAILED");
         $finish;
      end
   end

   task automatic flag_error(input string msg);
      fail_cnt++;
      $display("%s", msg);
   endtask

   a_t1_addr: assert property (@(posedge clk) disable iff (!rst)
      ale_o |-> ad_oe_o && ad_o == a_o[7:0])
      else flag_error($sformatf("ERR ad_o exp %h got %h", a_o[7:0], ad_o));
   a_kind: assert property (@(posedge clk) disable iff (!rst)
      (!rd_n_o || !wr_n_o) |-> iom_o == cur_io && dtr_o == cur_write)
      else flag_error($sformatf("ERR iom_o/dtr_o exp %h/%h got %h/%h",
                                cur_io, cur_write, iom_o, dtr_o));
   a_inta_kind: assert property (@(posedge clk) disable iff (!rst)
      !inta_n_o |-> iom_o && !dtr_o)
      else flag_error("acknowledge cycle without iom_o high or with dtr_o high");
   // den follows whichever strobe is active
   a_den: assert property (@(posedge clk) disable iff (!rst)
      den_n_o == (rd_n_o && wr_n_o && inta_n_o))
      else flag_error($sformatf("ERR den_n_o exp %h got %h",
                                rd_n_o && wr_n_o && inta_n_o, den_n_o));
   a_data_dir: assert property (@(posedge clk) disable iff (!rst)
      !den_n_o |-> ad_oe_o == !wr_n_o)
      else flag_error($sformatf("ERR ad_oe_o exp %h got %h", !wr_n_o, ad_oe_o));
   a_rsp_hold: assert property (@(posedge clk) disable iff (!rst)
      rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o) && !req_ready_o)
      else flag_error("response changed or request accepted under back-pressure");
   a_vec_hold: assert property (@(posedge clk) disable iff (!rst)
      vec_valid_o && !vec_ready_i |=> vec_valid_o && $stable(vec_o))
      else flag_error("vector dropped before it was taken");
   a_hold_quiet: assert property (@(posedge clk) disable iff (!rst)
      hlda_o |-> rd_n_o && wr_n_o && inta_n_o && !ale_o && !ad_oe_o)
      else flag_error("bus activity while hold was granted");
   a_float: assert property (@(posedge clk) disable iff (!rst)
      bus_float_o == hlda_o)
      else flag_error($sformatf("ERR bus_float_o exp %h got %h", hlda_o, bus_float_o));

   function logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic compare_value(input string name, input logic [19:0] got,
                                input logic [19:0] exp);
      if (got !== exp) begin
         fail_cnt++;
         $display("ERR %s exp %h got %h", name, exp, got);
      end else begin
         pass_cnt++;
      end
   endtask

   // one core request through to its response
   task automatic run_req(input bus_req_t r, input int waits, input int bp,
                          output logic [15:0] rdata);
      int acc;
      int nbytes;
      bus_rsp_t rsp;
      nbytes = r.byte_op ? 1 : 2;
      @(posedge clk);
      #2;
      wait_cnt = 4'(waits);
      cur_io = r.io;
      cur_write = r.write;
      ale_addrs.delete();
      req_i = r;
      req_valid_i = 1'b1;
      do @(negedge clk); while (!req_ready_o);
      @(posedge clk);
      #2 req_valid_i = 1'b0;
      @(negedge clk);
      acc = cyc;
      while (!rsp_valid_o) @(negedge clk);
      if (waits == 0)
         compare_value("latency", 20'(cyc - acc), 20'(4 * nbytes));
      else if (cyc - acc < 4 * nbytes)
         compare_value("latency", 20'(cyc - acc), 20'(4 * nbytes));
      rsp = rsp_o;
      repeat (bp) @(posedge clk);
      @(posedge clk);
      #2 rsp_ready_i = 1'b1;
      @(posedge clk);
      #2 rsp_ready_i = 1'b0;
      compare_value("rsp_o.was_write", 20'(rsp.was_write), 20'(r.write));
      compare_value("ale count", 20'(ale_addrs.size()), 20'(nbytes));
      for (int i = 0; i < nbytes && i < ale_addrs.size(); i++)
         compare_value("a_o", ale_addrs[i], r.addr + 20'(i));
      rdata = rsp.rdata;
   endtask

   // write then read back one random location, tracking expected bytes
   task automatic write_read(input bit zero_wait);
      bus_req_t r;
      logic [31:0] rnd;
      logic [15:0] got;
      logic [15:0] exp;
      logic [7:0] lo;
      logic [7:0] hi;
      r.addr = 20'(next_rand());
      r.wdata = 16'(next_rand() >> 8);
      rnd = next_rand();
      r.io = rnd[9];
      rnd = next_rand();
      r.byte_op = rnd[12];
      r.write = 1'b1;
      rnd = next_rand();  // wait count and back-pressure
      run_req(r, zero_wait ? 0 : int'(rnd[13:12]), int'(rnd[5:4]), got);
      if (r.io) begin
         ref_io[r.addr[3:0]] = r.wdata[7:0];
         if (!r.byte_op) ref_io[4'(r.addr[3:0] + 4'd1)] = r.wdata[15:8];
      end else begin
         ref_mem[r.addr[7:0]] = r.wdata[7:0];
         if (!r.byte_op) ref_mem[8'(r.addr[7:0] + 8'd1)] = r.wdata[15:8];
      end
      r.write = 1'b0;
      rnd = next_rand();
      run_req(r, zero_wait ? 0 : int'(rnd[13:12]), int'(rnd[5:4]), got);
      lo = r.io ? ref_io[r.addr[3:0]] : ref_mem[r.addr[7:0]];
      hi = r.io ? ref_io[4'(r.addr[3:0] + 4'd1)] : ref_mem[8'(r.addr[7:0] + 8'd1)];
      exp = r.byte_op ? {{8{lo[7]}}, lo} : {hi, lo};
      compare_value("rsp_o.rdata", 20'(got), 20'(exp));
   endtask

   task automatic report(input int num, input string name, input int fails_before);
      $display("test %0d %s: %0d errors", num, name, fail_cnt - fails_before);
   endtask

   initial begin
      int f0;
      bus_req_t r;
      logic [15:0] got;
      logic rsp_seen;
      lcg_state = 32'hd459;
      cyc = 0;
      pass_cnt = 0;
      fail_cnt = 0;
      inta_pulses = 0;
      inta_prev = 1'b1;
      rst = 1'b0;
      req_valid_i = 1'b0;
      req_i = '0;
      rsp_ready_i = 1'b0;
      vec_ready_i = 1'b0;
      hold_i = 1'b0;
      intr_i = 1'b0;
      wait_cnt = '0;
      vector = 8'h4c;
      cur_io = 1'b0;
      cur_write = 1'b0;
      repeat (16) @(posedge clk);
      #2 rst = 1'b1;

      f0 = fail_cnt;
      for (int i = 0; i < N_RAND; i++) write_read(1'b0);
      report(1, "random traffic with wait states", f0);

      f0 = fail_cnt;
      for (int i = 0; i < N_ZERO; i++) write_read(1'b1);
      report(2, "zero-wait latency", f0);

      f0 = fail_cnt;
      @(posedge clk);
      #2 intr_i = 1'b1;
      inta_pulses = 0;
      repeat (2) @(posedge clk);
      #2 intr_i = 1'b0;
      while (!vec_valid_o) @(negedge clk);
      repeat (3) @(posedge clk);
      @(negedge clk);
      compare_value("vec_o", 20'(vec_o), 20'(vector));
      compare_value("inta pulses", 20'(inta_pulses), 20'd2);
      @(posedge clk);
      #2 vec_ready_i = 1'b1;
      @(posedge clk);
      #2 vec_ready_i = 1'b0;
      report(3, "interrupt acknowledge", f0);

      f0 = fail_cnt;
      rsp_seen = 1'b0;
      r = '{addr: 20'h12345, wdata: 16'hbeef, write: 1'b1, io: 1'b0, byte_op: 1'b0};
      fork
         begin
            run_req(r, 2, 0, got);
            rsp_seen = 1'b1;
         end
         begin
            do @(negedge clk); while (!ale_o);
            @(posedge clk);
            #2 hold_i = 1'b1;
            while (!hlda_o) @(negedge clk);
            if (!rsp_valid_o && !rsp_seen) begin
               fail_cnt++;
               $display("hold granted before the bus cycle finished");
            end
            repeat (6) @(posedge clk);
            #2 hold_i = 1'b0;
            while (hlda_o) @(negedge clk);
         end
      join
      r.write = 1'b0;
      run_req(r, 0, 0, got);
      compare_value("rsp_o.rdata", 20'(got), 20'h0beef);
      report(4, "hold and resume", f0);

      $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && pass_cnt > 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* sim/bus_memory_model.sv */
// memory and I/O space on the multiplexed bus
// latches the address on ale, inserts wait states, answers the vector on inta

`timescale 1ns/10ps

module bus_memory_model (
   input  logic        clk,
   input  logic        rst,
   input  logic [19:0] a_i,
   input  logic [7:0]  wdata_i,   // ad from the DUT
   input  logic        ale_i,
   input  logic        rd_n_i,
   input  logic        wr_n_i,
   input  logic        inta_n_i,
   input  logic        iom_i,
   input  logic [3:0]  wait_cnt_i,
   input  logic [7:0]  vector_i,
   output logic [7:0]  ad_o,
   output logic        ready_o
);

   logic [7:0]  mem [256];
   logic [7:0]  io_mem [16];
   logic [19:0] addr_q;
   logic        iom_q;
   logic [3:0]  wait_q;
   logic        inta_n_q;
   logic        second_q;  // second acknowledge pulse

   initial begin
      for (int i = 0; i < 256; i++)
         mem[i] = 8'(i * 13 + 7);
      for (int i = 0; i < 16; i++)
         io_mem[i] = 8'(i * 29 + 3);
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         addr_q   <= '0;
         iom_q    <= 1'b0;
         wait_q   <= '0;
         inta_n_q <= 1'b1;
         second_q <= 1'b0;
      end else begin
         inta_n_q <= inta_n_i;
         if (inta_n_i && !inta_n_q)
            second_q <= ~second_q;  // end of a pulse
         if (ale_i) begin
            addr_q <= a_i;
            iom_q  <= iom_i;
            wait_q <= wait_cnt_i;
         end else if (wait_q != 0 && (!rd_n_i || !wr_n_i || !inta_n_i)) begin
            wait_q <= wait_q - 4'd1;
         end
         if (!wr_n_i && ready_o) begin
            if (iom_q)
               io_mem[addr_q[3:0]] <= wdata_i;
            else
               mem[addr_q[7:0]] <= wdata_i;
         end
      end
   end

   assign ready_o = (wait_q == 0);
   assign ad_o = !inta_n_i ? (second_q ? vector_i : 8'hff)
               : iom_q ? io_mem[addr_q[3:0]] : mem[addr_q[7:0]];

endmodule

/* hdl/biu_8088.sv */
// 8088 bus interface unit top
// core request/response side to the multiplexed 8-bit bus

`timescale 1ns/10ps

module biu_8088
   import biu_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   // core side
   input  logic              req_valid_i,
   input  bus_req_t          req_i,
   output logic              req_ready_o,
   output logic              rsp_valid_o,
   output bus_rsp_t          rsp_o,
   input  logic              rsp_ready_i,
   output logic              vec_valid_o,
   output logic [BYTE_W-1:0] vec_o,
   input  logic              vec_ready_i,
   // bus side
   input  logic              ready_i,
   input  logic              hold_i,
   input  logic              intr_i,
   input  logic [BYTE_W-1:0] ad_i,
   output logic [ADDR_W-1:0] a_o,
   output logic [BYTE_W-1:0] ad_o,
   output logic              ad_oe_o,
   output logic              ale_o,
   output logic              rd_n_o,
   output logic              wr_n_o,
   output logic              den_n_o,
   output logic              dtr_o,
   output logic              iom_o,
   output logic              inta_n_o,
   output logic              hlda_o,
   output logic              bus_float_o
);

   logic              bus_idle;
   logic              hold_req;
   logic              inta_req;
   logic              inta_cycle_done;
   logic              inta_second;
   logic              rsp_write;
   dp_ctrl_t          dp_ctrl;
   cycle_kind_e       cycle_kind;
   logic [DATA_W-1:0] rdata;

   assign rsp_o = '{rdata: rdata, was_write: rsp_write};

   bus_cycle_fsm u_fsm (
      .clk(clk), .rst(rst),
      .req_valid_i(req_valid_i), .req_io_i(req_i.io),
      .req_write_i(req_i.write), .req_byte_i(req_i.byte_op),
      .rsp_ready_i(rsp_ready_i), .hold_req_i(hold_req),
      .inta_req_i(inta_req), .ready_i(ready_i),
      .req_ready_o(req_ready_o), .rsp_valid_o(rsp_valid_o),
      .rsp_write_o(rsp_write), .bus_idle_o(bus_idle),
      .dp_ctrl_o(dp_ctrl), .cycle_kind_o(cycle_kind),
      .inta_cycle_done_o(inta_cycle_done), .inta_second_o(inta_second),
      .ale_o(ale_o), .rd_n_o(rd_n_o), .wr_n_o(wr_n_o), .den_n_o(den_n_o),
      .dtr_o(dtr_o), .iom_o(iom_o), .inta_n_o(inta_n_o)
   );

   bus_datapath u_dp (
      .clk(clk), .rst(rst),
      .req_i(req_i), .dp_ctrl_i(dp_ctrl), .cycle_kind_i(cycle_kind),
      .ad_i(ad_i), .bus_float_i(bus_float_o),
      .a_o(a_o), .ad_o(ad_o), .ad_oe_o(ad_oe_o), .rdata_o(rdata)
   );

   hold_arbiter u_hold (
      .clk(clk), .rst(rst),
      .hold_i(hold_i), .bus_idle_i(bus_idle),
      .hold_req_o(hold_req), .hlda_o(hlda_o), .bus_float_o(bus_float_o)
   );

   intr_ack_ctrl u_inta (
      .clk(clk), .rst(rst),
      .intr_i(intr_i),
      .inta_cycle_done_i(inta_cycle_done), .inta_second_i(inta_second),
      .vec_byte_i(rdata[BYTE_W-1:0]),  // vector lands in the low byte
      .vec_ready_i(vec_ready_i),
      .inta_req_o(inta_req), .vec_valid_o(vec_valid_o), .vec_o(vec_o)
   );

endmodule

/* hdl/intr_ack_ctrl.sv */
// interrupt acknowledge control
// latches intr, requests the two inta cycles, holds the vector for the core

`timescale 1ns/10ps

module intr_ack_ctrl
   import biu_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              intr_i,
   input  logic              inta_cycle_done_i,
   input  logic              inta_second_i,
   input  logic [BYTE_W-1:0] vec_byte_i,
   input  logic              vec_ready_i,
   output logic              inta_req_o,
   output logic              vec_valid_o,
   output logic [BYTE_W-1:0] vec_o
);

   logic              intr_q;
   logic              pending_q;
   logic              vec_valid_q;
   logic [BYTE_W-1:0] vec_q;
   logic              intr_rise;
   logic              ack_done;

   assign intr_rise = intr_i & ~intr_q;
   assign ack_done  = inta_cycle_done_i & inta_second_i;  // T4 of second cycle

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         intr_q      <= 1'b0;
         pending_q   <= 1'b0;
         vec_valid_q <= 1'b0;
      end else begin
         intr_q <= intr_i;
         if (intr_rise)
            pending_q <= 1'b1;
         else if (ack_done)
            pending_q <= 1'b0;
         if (ack_done)
            vec_valid_q <= 1'b1;
         else if (vec_valid_q && vec_ready_i)
            vec_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ack_done)
         vec_q <= vec_byte_i;
   end

   assign inta_req_o  = pending_q & ~vec_valid_q;  // one vector outstanding at most
   assign vec_valid_o = vec_valid_q;
   assign vec_o       = vec_q;

   a_vec_hold: assert property (@(posedge clk) disable iff (!rst)
      vec_valid_o && !vec_ready_i |=> vec_valid_o && $stable(vec_o));

endmodule

/* hdl/hold_arbiter.sv */
// hold request synchronizer and hlda grant
// floats the bus only between bus cycles

`timescale 1ns/10ps

module hold_arbiter (
   input  logic clk,
   input  logic rst,
   input  logic hold_i,
   input  logic bus_idle_i,
   output logic hold_req_o,
   output logic hlda_o,
   output logic bus_float_o
);

   typedef enum logic [1:0] {
      GR_RELEASED,
      GR_WAITING,  // hold seen, bus still busy
      GR_GRANTED
   } grant_e;

   logic   hold_s1_q;
   logic   hold_s2_q;
   grant_e grant_q;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         hold_s1_q <= 1'b0;
         hold_s2_q <= 1'b0;
         grant_q   <= GR_RELEASED;
      end else begin
         hold_s1_q <= hold_i;
         hold_s2_q <= hold_s1_q;
         case (grant_q)
            GR_RELEASED: if (hold_s2_q) grant_q <= bus_idle_i ? GR_GRANTED : GR_WAITING;
            GR_WAITING: begin
               if (!hold_s2_q)
                  grant_q <= GR_RELEASED;  // hold withdrawn before grant
               else if (bus_idle_i)
                  grant_q <= GR_GRANTED;
            end
            GR_GRANTED: if (!hold_s2_q) grant_q <= GR_RELEASED;
            default: grant_q <= GR_RELEASED;
         endcase
      end
   end

   assign hold_req_o  = hold_s2_q;
   assign hlda_o      = (grant_q == GR_GRANTED);
   assign bus_float_o = (grant_q == GR_GRANTED);

   a_hlda_idle: assert property (@(posedge clk) disable iff (!rst)
      $rose(hlda_o) |-> $past(bus_idle_i));

endmodule

/* hdl/bus_datapath.sv */
// bus datapath
// address and write data registers, ad multiplexing, read byte assembly

`timescale 1ns/10ps

module bus_datapath
   import biu_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  bus_req_t          req_i,
   input  dp_ctrl_t          dp_ctrl_i,
   input  cycle_kind_e       cycle_kind_i,
   input  logic [BYTE_W-1:0] ad_i,
   input  logic              bus_float_i,
   output logic [ADDR_W-1:0] a_o,
   output logic [BYTE_W-1:0] ad_o,
   output logic              ad_oe_o,
   output logic [DATA_W-1:0] rdata_o
);

   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] wdata_q;
   logic              byte_op_q;
   logic [BYTE_W-1:0] lo_q;
   logic [BYTE_W-1:0] hi_q;
   logic [BYTE_W-1:0] wr_byte;

   // request payload
   always_ff @(posedge clk) begin
      if (dp_ctrl_i.load_req) begin
         addr_q    <= req_i.addr;
         wdata_q   <= req_i.wdata;
         byte_op_q <= req_i.byte_op;
      end
   end

   // read byte capture
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         lo_q <= '0;
         hi_q <= '0;
      end else if (dp_ctrl_i.cap_byte) begin
         if (dp_ctrl_i.byte_idx)
            hi_q <= ad_i;
         else
            lo_q <= ad_i;
      end
   end

   assign a_o = addr_q + ADDR_W'(dp_ctrl_i.byte_idx);  // addr, then addr+1

   assign wr_byte = dp_ctrl_i.byte_idx ? wdata_q[DATA_W-1:BYTE_W] : wdata_q[BYTE_W-1:0];
   assign ad_o    = dp_ctrl_i.drive_addr ? a_o[BYTE_W-1:0] : wr_byte;
   assign ad_oe_o = (dp_ctrl_i.drive_addr | dp_ctrl_i.drive_data) & ~bus_float_i;

   always_comb begin
      if (cycle_kind_i == CYC_INTA)
         rdata_o = {{BYTE_W{1'b0}}, lo_q};  // vector byte
      else if (byte_op_q)
         rdata_o = {{BYTE_W{lo_q[BYTE_W-1]}}, lo_q};  // sign extend for the core
      else
         rdata_o = {hi_q, lo_q};
   end

   // sequencer never asks for the bus while it is granted away
   a_float_quiet: assert property (@(posedge clk) disable iff (!rst)
      bus_float_i |-> !dp_ctrl_i.drive_addr && !dp_ctrl_i.drive_data);

endmodule

/* hdl/bus_cycle_fsm.sv */
// bus cycle sequencer
// runs T1..T4 byte cycles, splits words, arbitrates hold, acknowledge and core requests

`timescale 1ns/10ps

module bus_cycle_fsm
   import biu_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        req_valid_i,
   input  logic        req_io_i,
   input  logic        req_write_i,
   input  logic        req_byte_i,
   input  logic        rsp_ready_i,
   input  logic        hold_req_i,
   input  logic        inta_req_i,
   input  logic        ready_i,
   output logic        req_ready_o,
   output logic        rsp_valid_o,
   output logic        rsp_write_o,
   output logic        bus_idle_o,
   output dp_ctrl_t    dp_ctrl_o,
   output cycle_kind_e cycle_kind_o,
   output logic        inta_cycle_done_o,
   output logic        inta_second_o,
   output logic        ale_o,
   output logic        rd_n_o,
   output logic        wr_n_o,
   output logic        den_n_o,
   output logic        dtr_o,
   output logic        iom_o,
   output logic        inta_n_o
);

   tstate_e     state_q;
   cycle_kind_e kind_q;
   logic        write_q;
   logic        byte_q;
   logic        byte_cnt_q;  // byte of the word in progress
   logic        second_q;    // second acknowledge cycle
   logic        rsp_valid_q;
   logic        accept;
   logic        start_inta;
   logic        last_byte;
   logic        strobe_ph;   // T2 and T3
   logic        in_cycle;

   // no new work while a response waits, hold still wins
   assign req_ready_o = (state_q == TS_IDLE) & ~hold_req_i & ~inta_req_i & ~rsp_valid_q;
   assign start_inta  = (state_q == TS_IDLE) & ~hold_req_i & inta_req_i & ~rsp_valid_q;
   assign accept      = req_valid_i & req_ready_o;
   assign last_byte   = byte_q | byte_cnt_q;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state_q     <= TS_IDLE;
         kind_q      <= CYC_MEM;
         write_q     <= 1'b0;
         byte_q      <= 1'b0;
         byte_cnt_q  <= 1'b0;
         second_q    <= 1'b0;
         rsp_valid_q <= 1'b0;
      end else begin
         if (rsp_valid_q && rsp_ready_i)
            rsp_valid_q <= 1'b0;
         case (state_q)
            TS_IDLE: begin
               if (hold_req_i) begin
                  state_q <= TS_HOLD;
               end else if (start_inta) begin
                  state_q    <= TS_T1;
                  kind_q     <= CYC_INTA;
                  write_q    <= 1'b0;
                  byte_q     <= 1'b1;
                  byte_cnt_q <= 1'b0;
                  second_q   <= 1'b0;
               end else if (accept) begin
                  state_q    <= TS_T1;
                  kind_q     <= req_io_i ? CYC_IO : CYC_MEM;
                  write_q    <= req_write_i;
                  byte_q     <= req_byte_i;
                  byte_cnt_q <= 1'b0;
               end
            end
            TS_T1: state_q <= TS_T2;
            TS_T2: state_q <= TS_T3;
            TS_T3: if (ready_i) state_q <= TS_T4;  // wait states
            TS_T4: begin
               if (kind_q == CYC_INTA) begin
                  if (second_q) begin
                     state_q <= TS_IDLE;
                  end else begin
                     state_q  <= TS_T1;  // acknowledge pair stays atomic
                     second_q <= 1'b1;
                  end
               end else if (last_byte) begin
                  state_q     <= TS_IDLE;
                  rsp_valid_q <= 1'b1;
               end else begin
                  state_q    <= TS_T1;  // high byte at addr+1
                  byte_cnt_q <= 1'b1;
               end
            end
            TS_HOLD: if (!hold_req_i) state_q <= TS_IDLE;
            default: state_q <= TS_IDLE;
         endcase
      end
   end

   assign strobe_ph  = (state_q == TS_T2) | (state_q == TS_T3);
   assign bus_idle_o = (state_q == TS_IDLE) | (state_q == TS_HOLD);
   assign in_cycle   = ~bus_idle_o;

   // bus strobes
   assign ale_o    = (state_q == TS_T1);
   assign rd_n_o   = ~(strobe_ph & ~write_q & (kind_q != CYC_INTA));
   assign wr_n_o   = ~(strobe_ph & write_q);
   assign inta_n_o = ~(strobe_ph & (kind_q == CYC_INTA));
   assign den_n_o  = ~strobe_ph;
   assign dtr_o    = in_cycle & write_q;
   assign iom_o    = in_cycle & (kind_q != CYC_MEM);

   always_comb begin
      dp_ctrl_o.load_req   = accept;
      dp_ctrl_o.drive_addr = (state_q == TS_T1);
      dp_ctrl_o.drive_data = write_q & (strobe_ph | (state_q == TS_T4));
      dp_ctrl_o.byte_idx   = byte_cnt_q;
      dp_ctrl_o.cap_byte   = (state_q == TS_T3) & ready_i & ~write_q;
   end

   assign cycle_kind_o      = kind_q;
   assign inta_cycle_done_o = (state_q == TS_T4) & (kind_q == CYC_INTA);
   assign inta_second_o     = second_q;
   assign rsp_valid_o       = rsp_valid_q;
   assign rsp_write_o       = write_q;

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst)
      !(!rd_n_o && !wr_n_o));

   // ale marks T1 only, always followed by T2
   a_ale_t1: assert property (@(posedge clk) disable iff (!rst)
      ale_o |=> (state_q == TS_T2));

endmodule

/* hdl/biu_pkg.sv */
// bus interface unit shared types
// request, response and sequencer control for the 8088 style bus

package biu_pkg;

   localparam int ADDR_W = 20;  // physical address
   localparam int DATA_W = 16;  // core data word
   localparam int BYTE_W = 8;   // multiplexed bus lane

   // core request, one transfer of a byte or a word
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic              write;
      logic              io;
      logic              byte_op;
   } bus_req_t;

   // completion returned for every request
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              was_write;
   } bus_rsp_t;

   // sequencer to datapath strobes
   typedef struct packed {
      logic load_req;    // capture accepted request
      logic drive_addr;  // address phase on ad
      logic drive_data;  // write data phase on ad
      logic byte_idx;    // 0 low byte, 1 high byte
      logic cap_byte;    // sample ad_i into selected byte
   } dp_ctrl_t;

   typedef enum logic [2:0] {
      TS_IDLE,
      TS_T1,
      TS_T2,
      TS_T3,
      TS_T4,
      TS_HOLD
   } tstate_e;

   typedef enum logic [1:0] {
      CYC_MEM,
      CYC_IO,
      CYC_INTA
   } cycle_kind_e;

endpackage
